// ==== board_lab_cfg_pkg.sv ====
package board_lab_cfg_pkg;

    //----------------------------------------------------------------------
    // Board

    localparam int clk_mhz       = 50;

    localparam int w_key         = 2;
    localparam int w_sw          = 9;
    localparam int w_led         = 10;
    localparam int w_digit       = 6;   // HEX0..HEX5

    //----------------------------------------------------------------------
    // VGA 640x480 at 60 Hz, counted in pixels and lines

    localparam int screen_width  = 640;
    localparam int screen_height = 480;

    localparam int h_total       = 800;
    localparam int h_sync_start  = 656;
    localparam int h_sync_len    = 96;

    localparam int v_total       = 525;
    localparam int v_sync_start  = 490;
    localparam int v_sync_len    = 2;

    localparam int w_x           = 10;
    localparam int w_y           = 10;
    localparam int w_color       = 4;   // Bits per colour channel

    //----------------------------------------------------------------------
    // Lab block

    localparam int scan_slot_clocks = 4096;  // Clocks each digit stays selected
    localparam int w_count          = 16;

endpackage

// ==== board_lab_disp_pkg.sv ====
package board_lab_disp_pkg;

    // Registered VGA timing bundle
    typedef struct packed {
        logic                             hsync;       // Active low
        logic                             vsync;       // Active low
        logic                             display_on;
        logic [board_lab_cfg_pkg::w_x-1:0] x;
        logic [board_lab_cfg_pkg::w_y-1:0] y;
    } vga_timing_t;

    typedef struct packed {
        logic [board_lab_cfg_pkg::w_color-1:0] red;
        logic [board_lab_cfg_pkg::w_color-1:0] green;
        logic [board_lab_cfg_pkg::w_color-1:0] blue;
    } rgb_t;

    // Dynamic display, one digit lit at a time
    typedef struct packed {
        logic [7:0]                            abcdefgh;  // Segment a is the MSB
        logic [board_lab_cfg_pkg::w_digit-1:0] digit;     // One-hot
    } seg_scan_t;

    // Codes also shown on HEX5
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_run   = 2'd1,
        st_pause = 2'd2
    } lab_state_t;

    // Hex digit to active-high segments, decimal point off
    function automatic logic [7:0] seg_hex(input logic [3:0] value);
        case (value)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;   // F
        endcase
    endfunction

endpackage

// ==== slow_strobe_gen.sv ====
`timescale 1ns/1ps

module slow_strobe_gen
#(
    parameter int strobe_hz = 1
)
(
    input        clk,
    input        rst,
    output logic tick
);

    import board_lab_cfg_pkg::*;

    // Clocks between two ticks
    localparam int period = clk_mhz * 1_000_000 / strobe_hz;

    logic [$clog2(period)-1:0] cnt;

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            cnt  <= ($clog2(period))'(period - 1);
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= ($clog2(period))'(period - 1);  // Reload
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end

    tick_single_cycle: assert property (@(posedge clk) disable iff (rst) tick |=> !tick)
        else $error("tick held high for two cycles");

endmodule

// ==== vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing
(
    input                                    clk,
    input                                    rst,
    output board_lab_disp_pkg::vga_timing_t  timing
);

    import board_lab_cfg_pkg::*;
    import board_lab_disp_pkg::*;

    logic           pix_en;   // Every second clock, 25 MHz
    logic [w_x-1:0] h_cnt;
    logic [w_y-1:0] v_cnt;

    always_ff @(posedge clk or posedge rst)
        if (rst)
            pix_en <= 1'b0;
        else
            pix_en <= ~pix_en;

    //----------------------------------------------------------------------
    // Position counters

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (pix_en)
        begin
            if (h_cnt == w_x'(h_total - 1))
            begin
                h_cnt <= '0;

                if (v_cnt == w_y'(v_total - 1))
                    v_cnt <= '0;
                else
                    v_cnt <= v_cnt + 1'b1;
            end
            else
            begin
                h_cnt <= h_cnt + 1'b1;
            end
        end

    //----------------------------------------------------------------------
    // Registered decodes, all fields describe the same pixel

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            timing.hsync      <= 1'b1;
            timing.vsync      <= 1'b1;
            timing.display_on <= 1'b0;
            timing.x          <= '0;
            timing.y          <= '0;
        end
        else
        begin
            timing.hsync      <= !(h_cnt >= h_sync_start
                                   && h_cnt < h_sync_start + h_sync_len);
            timing.vsync      <= !(v_cnt >= v_sync_start
                                   && v_cnt < v_sync_start + v_sync_len);
            timing.display_on <= h_cnt < screen_width && v_cnt < screen_height;
            timing.x          <= h_cnt;
            timing.y          <= v_cnt;
        end

    x_in_line: assert property (@(posedge clk) disable iff (rst) timing.x < h_total)
        else $error("x beyond line length");

    on_screen: assert property (@(posedge clk) disable iff (rst)
        timing.display_on |-> timing.x < screen_width && timing.y < screen_height)
        else $error("display_on outside the visible area");

endmodule

// ==== lab_control.sv ====
`timescale 1ns/1ps

module lab_control
(
    input                                           clk,
    input                                           rst,
    input        [board_lab_cfg_pkg::w_key-1:0]     key,     // Active high
    input        [3:0]                              step,
    input                                           tick,
    input        board_lab_disp_pkg::vga_timing_t   timing,
    output logic [board_lab_cfg_pkg::w_count-1:0]   count,
    output       board_lab_disp_pkg::lab_state_t    state,
    output       board_lab_disp_pkg::rgb_t          rgb,
    output logic [board_lab_cfg_pkg::w_led-1:0]     led
);

    import board_lab_cfg_pkg::*;
    import board_lab_disp_pkg::*;

    logic [w_key-1:0] key_s1;
    logic [w_key-1:0] key_s2;
    logic [w_key-1:0] key_s3;   // Previous synchronised level
    logic [w_key-1:0] press;

    //----------------------------------------------------------------------
    // Key synchroniser and press detect

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            key_s1 <= '0;
            key_s2 <= '0;
            key_s3 <= '0;
        end
        else
        begin
            key_s1 <= key;
            key_s2 <= key_s1;
            key_s3 <= key_s2;
        end

    assign press = key_s2 & ~key_s3;

    //----------------------------------------------------------------------
    // State machine

    always_ff @(posedge clk or posedge rst)
        if (rst)
            state <= st_idle;
        else
            case (state)
                st_idle:  if (press[0]) state <= st_run;
                st_run:   if (press[1]) state <= st_pause;
                st_pause: if (press[0]) state <= st_run;  // Resume
                default:  state <= st_idle;
            endcase

    // Stopwatch counter, wraps at 16 bits
    always_ff @(posedge clk or posedge rst)
        if (rst)
            count <= '0;
        else if (tick && state == st_run)
            count <= count + w_count'(step);

    //----------------------------------------------------------------------
    // Outputs

    always_comb
    begin
        if (timing.display_on)
        begin
            rgb.red   = count[11:8];
            rgb.green = count[7:4];
            rgb.blue  = count[3:0];
        end
        else
        begin
            rgb = '0;   // Blanking
        end
    end

    assign led = count[w_led-1:0];

    count_only_on_tick: assert property (@(posedge clk) disable iff (rst)
        !$stable(count) |-> $past(tick && state == st_run))
        else $error("counter moved without a tick in st_run");

endmodule

// ==== seg7_scanner.sv ====
`timescale 1ns/1ps

module seg7_scanner
(
    input                                          clk,
    input                                          rst,
    input        [board_lab_cfg_pkg::w_count-1:0]  count,
    input        [3:0]                             step,
    input        board_lab_disp_pkg::lab_state_t   state,
    output       board_lab_disp_pkg::seg_scan_t    scan
);

    import board_lab_cfg_pkg::*;
    import board_lab_disp_pkg::*;

    logic [$clog2(scan_slot_clocks)-1:0] slot_cnt;
    logic [w_digit-1:0]                  digit_r;
    logic [3:0]                          nibble;

    //----------------------------------------------------------------------
    // Slot timer and digit rotation

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            slot_cnt <= '0;
            digit_r  <= w_digit'(1);
        end
        else if (slot_cnt == ($clog2(scan_slot_clocks))'(scan_slot_clocks - 1))
        begin
            slot_cnt <= '0;
            digit_r  <= {digit_r[w_digit-2:0], digit_r[w_digit-1]};  // Rotate left
        end
        else
        begin
            slot_cnt <= slot_cnt + 1'b1;
        end

    //----------------------------------------------------------------------
    // Nibble select, counter on digits 0..3

    always_comb
    begin
        nibble = '0;

        for (int k = 0; k < 4; k++)
            if (digit_r[k])
                nibble = count[k * 4 +: 4];

        if (digit_r[4])
            nibble = step;

        if (digit_r[5])
            nibble = 4'(state);   // State code
    end

    always_comb
    begin
        scan.digit    = digit_r;
        scan.abcdefgh = seg_hex(nibble);
    end

    digit_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot(digit_r))
        else $error("digit select lost its one-hot form");

endmodule

// ==== seg7_static_latch.sv ====
`timescale 1ns/1ps

module seg7_static_latch
(
    input                                       clk,
    input                                       rst,
    input        board_lab_disp_pkg::seg_scan_t scan,
    output logic [7:0]                          hex0,
    output logic [7:0]                          hex1,
    output logic [7:0]                          hex2,
    output logic [7:0]                          hex3,
    output logic [7:0]                          hex4,
    output logic [7:0]                          hex5
);

    import board_lab_disp_pkg::*;

    logic [7:0] hgfedcba;

    // Board pins want segment a on bit 0
    generate
        for (genvar i = 0; i < 8; i++)
        begin : rev
            assign hgfedcba[i] = scan.abcdefgh[7 - i];
        end
    endgenerate

    //----------------------------------------------------------------------
    // Sticky digits, each keeps the last value seen while selected

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            {hex0, hex1, hex2, hex3, hex4, hex5} <= '1;  // Blank
        end
        else
        begin
            if (scan.digit[0]) hex0 <= ~hgfedcba;
            if (scan.digit[1]) hex1 <= ~hgfedcba;
            if (scan.digit[2]) hex2 <= ~hgfedcba;
            if (scan.digit[3]) hex3 <= ~hgfedcba;
            if (scan.digit[4]) hex4 <= ~hgfedcba;
            if (scan.digit[5]) hex5 <= ~hgfedcba;
        end

endmodule

// ==== board_top.sv ====
`timescale 1ns/1ps

module board_top
#(
    parameter int strobe_hz = 1
)
(
    input                                         clk,
    input                                         rst,
    input        [board_lab_cfg_pkg::w_key-1:0]   key,     // Active low
    input        [board_lab_cfg_pkg::w_sw-1:0]    sw,
    output       [board_lab_cfg_pkg::w_led-1:0]   led,
    output logic [7:0]                            hex0,
    output logic [7:0]                            hex1,
    output logic [7:0]                            hex2,
    output logic [7:0]                            hex3,
    output logic [7:0]                            hex4,
    output logic [7:0]                            hex5,
    output                                        vga_hs,
    output                                        vga_vs,
    output       [board_lab_cfg_pkg::w_color-1:0] vga_r,
    output       [board_lab_cfg_pkg::w_color-1:0] vga_g,
    output       [board_lab_cfg_pkg::w_color-1:0] vga_b
);

    import board_lab_cfg_pkg::*;
    import board_lab_disp_pkg::*;

    logic               tick;
    vga_timing_t        timing;
    logic [w_count-1:0] count;
    lab_state_t         state;
    rgb_t               rgb;
    seg_scan_t          scan;

    //----------------------------------------------------------------------

    slow_strobe_gen #(.strobe_hz(strobe_hz)) i_strobe (.clk, .rst, .tick);

    vga_timing i_vga (.clk, .rst, .timing);

    lab_control i_lab
    (
        .clk    ( clk      ),
        .rst    ( rst      ),
        .key    ( ~key     ),
        .step   ( sw[3:0]  ),
        .tick   ( tick     ),
        .timing ( timing   ),
        .count  ( count    ),
        .state  ( state    ),
        .rgb    ( rgb      ),
        .led    ( led      )
    );

    seg7_scanner i_scan (.clk, .rst, .count, .step(sw[3:0]), .state, .scan);

    seg7_static_latch i_hex (.clk, .rst, .scan, .hex0, .hex1, .hex2, .hex3, .hex4, .hex5);

    // Pins
    assign vga_hs = timing.hsync;
    assign vga_vs = timing.vsync;
    assign vga_r  = rgb.red;
    assign vga_g  = rgb.green;
    assign vga_b  = rgb.blue;

endmodule

// ==== tb_board_top.sv ====
`timescale 1ns/1ps

module tb_board_top;

    import board_lab_cfg_pkg::*;
    import board_lab_disp_pkg::*;

    localparam int     strobe_hz   = 50_000;   // One tick every 1000 clocks
    localparam int     clk_period  = 40;
    localparam longint tick_clocks = clk_mhz * 1_000_000 / strobe_hz;
    localparam longint line_clocks = 2 * h_total;
    localparam longint slot_wait   = 7 * scan_slot_clocks;   // Worst hex update latency
    localparam longint test_clocks = 24 + 25 * tick_clocks + line_clocks * (v_total + 4)
                                     + 2 * slot_wait;
    localparam longint watchdog_ns = 2 * test_clocks * clk_period;

    logic               clk;
    logic               rst;
    logic [w_key-1:0]   key;
    logic [w_sw-1:0]    sw;
    logic [w_led-1:0]   led;
    logic [7:0]         hex [w_digit];
    logic               vga_hs;
    logic               vga_vs;
    logic [w_color-1:0] vga_r;
    logic [w_color-1:0] vga_g;
    logic [w_color-1:0] vga_b;

    // Reference model
    logic [w_count-1:0] model_count;
    lab_state_t         model_state;
    logic               model_tick;
    longint             div_cnt;
    longint             edge_cnt;   // Clock edges since reset release
    string              test_name;
    logic [3:0]         step_val;
    logic [w_count-1:0] held;

    board_top #(.strobe_hz(strobe_hz)) DUT
    (
        .clk, .rst, .key, .sw, .led,
        .hex0(hex[0]), .hex1(hex[1]), .hex2(hex[2]),
        .hex3(hex[3]), .hex4(hex[4]), .hex5(hex[5]),
        .vga_hs, .vga_vs, .vga_r, .vga_g, .vga_b
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    //----------------------------------------------------------------------
    // Model divider and counter

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            div_cnt     <= 0;
            model_tick  <= 1'b0;
            edge_cnt    <= 0;
            model_count <= '0;
        end
        else
        begin
            edge_cnt   <= edge_cnt + 1;
            model_tick <= div_cnt == tick_clocks - 1;
            div_cnt    <= (div_cnt == tick_clocks - 1) ? 0 : div_cnt + 1;
            if (model_tick && model_state == st_run)
                model_count <= model_count + w_count'(sw[3:0]);   // Wraps at 16 bits
        end

    // Sync levels and colour against the model's pixel position
    always @(negedge clk)
    begin
        longint pix;
        longint px;
        longint py;
        if (!rst && edge_cnt > 0)
        begin
            pix = (edge_cnt - 1) / 2;   // One pixel per two clocks
            px  = pix % h_total;
            py  = (pix / h_total) % v_total;
            assert (vga_hs == !(px >= h_sync_start && px < h_sync_start + h_sync_len))
                else report_mismatch("hsync_at_position", !vga_hs, vga_hs);
            assert (vga_vs == !(py >= v_sync_start && py < v_sync_start + v_sync_len))
                else report_mismatch("vsync_at_position", !vga_vs, vga_vs);
            if (px >= screen_width || py >= screen_height)
            begin
                assert ({vga_r, vga_g, vga_b} == '0)
                    else report_mismatch("blank_colour", 0, {vga_r, vga_g, vga_b});
            end
            else
            begin
                assert ({vga_r, vga_g, vga_b} == model_count[11:0])
                    else report_mismatch("pixel_colour", model_count[11:0],
                                         {vga_r, vga_g, vga_b});
            end
        end
    end

    led_after_tick: assert property (@(posedge clk) disable iff (rst)
        $past(model_tick, 2) |-> led == model_count[w_led-1:0])
        else report_mismatch("led_after_tick", model_count[w_led-1:0], led);

    //----------------------------------------------------------------------

    task automatic report_mismatch(input string what, input longint expected,
                                   input longint actual);
        $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    // Board pin pattern, segment a on bit 0, active low
    function automatic logic [7:0] hex_pins(input logic [3:0] value);
        logic [7:0] seg;
        logic [7:0] pins;
        seg = seg_hex(value);
        for (int i = 0; i < 8; i++)
            pins[i] = ~seg[7 - i];
        return pins;
    endfunction

    task automatic check_reset_outputs();
        for (int k = 0; k < w_digit; k++)
            assert (hex[k] == 8'hff)
                else report_mismatch($sformatf("hex%0d_blank", k), 8'hff, hex[k]);
        assert (led == '0) else report_mismatch("led_reset", 0, led);
        assert (vga_hs && vga_vs) else report_mismatch("sync_reset", 2'b11, {vga_hs, vga_vs});
        assert ({vga_r, vga_g, vga_b} == '0)
            else report_mismatch("colour_reset", 0, {vga_r, vga_g, vga_b});
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst         = 1'b1;
        model_state = st_idle;
        repeat (10)
        begin
            @(negedge clk);
            check_reset_outputs();
        end
        rst = 1'b0;
        #1;
        check_reset_outputs();   // Before the first edge after release
    endtask

    // Returns one falling edge after the n-th tick
    task automatic wait_ticks(input int n);
        repeat (n)
        begin
            while (model_tick !== 1'b1) @(negedge clk);
            @(negedge clk);
        end
    endtask

    task automatic press_key(input int idx);
        wait_ticks(1);   // Keep the press clear of any tick
        repeat (10) @(negedge clk);
        key[idx] = 1'b0;
        repeat (4) @(negedge clk);
        key[idx] = 1'b1;
        repeat (4) @(negedge clk);
        if (idx == 0 && model_state != st_run)
            model_state = st_run;
        else if (idx == 1 && model_state == st_run)
            model_state = st_pause;
    endtask

    task automatic measure_sync(input bit vertical, output int low_len, output int period_len);
        low_len = 0;
        while ((vertical ? vga_vs : vga_hs) !== 1'b1) @(negedge clk);
        while ((vertical ? vga_vs : vga_hs) !== 1'b0) @(negedge clk);
        while ((vertical ? vga_vs : vga_hs) === 1'b0)
        begin
            low_len++;
            @(negedge clk);
        end
        period_len = low_len;
        if (!vertical)
        begin
            while (vga_hs === 1'b1)
            begin
                period_len++;
                @(negedge clk);
            end
        end
    endtask

    task automatic check_hex();
        logic [3:0] nib [w_digit];
        for (int k = 0; k < 4; k++)
            nib[k] = model_count[k * 4 +: 4];
        nib[4] = sw[3:0];
        nib[5] = 4'(model_state);   // State code on HEX5
        for (int k = 0; k < w_digit; k++)
            assert (hex[k] == hex_pins(nib[k]))
                else report_mismatch($sformatf("hex%0d", k), hex_pins(nib[k]), hex[k]);
    endtask

    //----------------------------------------------------------------------
    // Stimulus

    initial
    begin
        int         hs_low;
        int         hs_period;
        int         vs_low;
        int         vs_unused;
        logic [3:0] new_step;

        void'($urandom(32'h9251_cd86));
        rst         = 1'b1;
        key         = '1;   // Released
        sw          = '0;
        model_state = st_idle;

        test_name = "reset";
        apply_reset();

        test_name = "count";
        step_val  = 4'($urandom_range(15, 1));
        @(negedge clk);
        sw[3:0] = step_val;
        press_key(0);
        wait_ticks(5);
        assert (led == w_led'(5 * step_val)) else report_mismatch("five_ticks", 5 * step_val, led);

        test_name = "vga";
        measure_sync(1'b0, hs_low, hs_period);
        assert (hs_low == 2 * h_sync_len)
            else report_mismatch("hsync_low", 2 * h_sync_len, hs_low);
        assert (hs_period == line_clocks)
            else report_mismatch("hsync_period", line_clocks, hs_period);
        measure_sync(1'b1, vs_low, vs_unused);
        assert (vs_low == v_sync_len * line_clocks)
            else report_mismatch("vsync_low", v_sync_len * line_clocks, vs_low);

        test_name = "pause";
        press_key(1);
        held = model_count;
        wait_ticks(3);
        assert (led == held[w_led-1:0]) else report_mismatch("held_count", held[w_led-1:0], led);
        repeat (slot_wait) @(negedge clk);
        check_hex();

        test_name = "resume";
        press_key(0);
        wait_ticks(3);
        assert (led == w_led'(held + 3 * step_val))
            else report_mismatch("resumed_count", w_led'(held + 3 * step_val), led);

        test_name = "step";
        press_key(1);
        held = model_count;
        do
            new_step = 4'($urandom_range(15, 1));
        while (new_step == sw[3:0]);
        sw[3:0] = new_step;
        repeat (slot_wait) @(negedge clk);
        check_hex();
        assert (led == held[w_led-1:0]) else report_mismatch("count_kept", held[w_led-1:0], led);

        test_name = "reset_mid_run";
        press_key(0);
        wait_ticks(2);
        apply_reset();

        $display("SIMULATION PASSED");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== board_lab.f ====
board_lab_cfg_pkg.sv
board_lab_disp_pkg.sv
slow_strobe_gen.sv
vga_timing.sv
lab_control.sv
seg7_scanner.sv
seg7_static_latch.sv
board_top.sv
tb_board_top.sv

// ==== Makefile ====
# Verilator build for the board lab testbench

VERILATOR  ?= verilator
TOP        ?= tb_board_top
RTL_TOP    ?= board_top
FILELIST   ?= board_lab.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
